// ==== compile.f ====
logic/isaPkg.sv
logic/pipePkg.sv
logic/fetchStage.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/hazardUnit.sv
logic/mipsCore.sv
tb/coreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run coreTb with Verilator, verdict taken from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert -f compile.f --top-module coreTb -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/VcoreTb > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with a failing status"
    exit 1
fi
cat "$LOG"

if grep -qx "Done: no errors" "$LOG"; then
    exit 0
fi
exit 1

// ==== tb/prog.hex ====
// instruction words from address 0 upward, one per line, assembly after each word
3C011234 // 00 lui   $1, 0x1234
34215678 // 04 ori   $1, $1, 0x5678
24020010 // 08 addiu $2, $0, 0x10
00221821 // 0c addu  $3, $1, $2
00612023 // 10 subu  $4, $3, $1
00812824 // 14 and   $5, $4, $1
00A33026 // 18 xor   $6, $5, $3
00063900 // 1c sll   $7, $6, 4
000740C2 // 20 srl   $8, $7, 3
0101482A // 24 slt   $9, $8, $1
30EAFF00 // 28 andi  $10, $7, 0xff00
8C4B0008 // 2c lw    $11, 8($2)
016B6021 // 30 addu  $12, $11, $11
AC4C0004 // 34 sw    $12, 4($2)
8C4D0004 // 38 lw    $13, 4($2)
AC0D0020 // 3c sw    $13, 0x20($0)
8C0E0030 // 40 lw    $14, 0x30($0)
AC4E0034 // 44 sw    $14, 0x34($2)
10220005 // 48 beq   $1, $2, +5    not taken
14220002 // 4c bne   $1, $2, +2    to 58
240F0001 // 50 addiu $15, $0, 1    wrong path
240F0002 // 54 addiu $15, $0, 2    wrong path
10630001 // 58 beq   $3, $3, +1    to 60
24100003 // 5c addiu $16, $0, 3    wrong path
0C00001B // 60 jal   0x6c
24110005 // 64 addiu $17, $0, 5    wrong path
0800001E // 68 j     0x78
03E09821 // 6c addu  $19, $31, $0
0800001A // 70 j     0x68
24120006 // 74 addiu $18, $0, 6    wrong path
167F0001 // 78 bne   $19, $31, +1  not taken
026EA025 // 7c or    $20, $19, $14
24000055 // 80 addiu $0, $0, 0x55
08000021 // 84 j     0x84          end loop

// ==== tb/coreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreTb;

    localparam pipePkg::wordT RESET_PC       = 32'h0000_0000;
    localparam int unsigned   RAND_SEED      = 32'hac854cd9;
    localparam int            RESET_CYCLES   = 16;
    localparam int            TIMEOUT_CYCLES = 2000;
    localparam int            DRAIN_CYCLES   = 20;
    localparam int            MODEL_STEPS    = 1000;

    typedef struct packed {
        pipePkg::wordT   pc;
        isaPkg::regAddrT dest;
        pipePkg::wordT   data;
    } wbEntryT;

    typedef struct packed {
        pipePkg::wordT addr;
        pipePkg::wordT data;
    } storeEntryT;

    logic            clk;
    logic            rst_i;
    pipePkg::wordT   imemAddr_o;
    pipePkg::wordT   imemData_i;
    logic            dmemEn_o;
    logic            dmemWe_o;
    pipePkg::wordT   dmemAddr_o;
    pipePkg::wordT   dmemWdata_o;
    pipePkg::wordT   dmemRdata_i;
    logic            wbValid_o;
    pipePkg::wordT   wbPc_o;
    pipePkg::wordT   wbData_o;
    isaPkg::regAddrT wbReg_o;

    pipePkg::wordT rom [256];
    pipePkg::wordT ram [64];
    pipePkg::wordT initWords [64]; // loaded into ram during reset
    wbEntryT       expWb [$];
    storeEntryT    expSt [$];
    int            valueErrors = 0;
    int            otherErrors = 0;

    mipsCore #(.RESET_PC(RESET_PC)) mipsCore_inst (
        .clk(clk), .rst_i(rst_i),
        .imemAddr_o(imemAddr_o), .imemData_i(imemData_i),
        .dmemEn_o(dmemEn_o), .dmemWe_o(dmemWe_o),
        .dmemAddr_o(dmemAddr_o), .dmemWdata_o(dmemWdata_o),
        .dmemRdata_i(dmemRdata_i),
        .wbValid_o(wbValid_o), .wbPc_o(wbPc_o),
        .wbData_o(wbData_o), .wbReg_o(wbReg_o)
    );

    always #2 clk = ~clk;

    assign imemData_i  = rom[imemAddr_o[9:2]];
    assign dmemRdata_i = ram[dmemAddr_o[7:2]];

    always @(posedge clk) begin
        if (rst_i) begin
            ram <= initWords;
        end else if (dmemEn_o && dmemWe_o) begin
            ram[dmemAddr_o[7:2]] <= dmemWdata_o;
        end
    end

    task automatic checkValue(input string name, input pipePkg::wordT expected,
                              input pipePkg::wordT actual);
        assert (actual === expected) else begin
            valueErrors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // in-order ISA model, no delay slot, fills expWb and expSt
    task automatic runModel();
        pipePkg::wordT   regs [32];
        pipePkg::wordT   mem [64];
        pipePkg::wordT   pc;
        pipePkg::wordT   nextPc;
        pipePkg::wordT   instr;
        pipePkg::wordT   a;
        pipePkg::wordT   b;
        pipePkg::wordT   simm;
        pipePkg::wordT   res;
        pipePkg::wordT   addr;
        isaPkg::regAddrT dest;
        logic            wr;
        logic            done;
        int              steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        mem   = initWords;
        pc    = RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < MODEL_STEPS) begin
            instr  = rom[pc[9:2]];
            a      = regs[instr[25:21]];
            b      = regs[instr[20:16]];
            simm   = {{16{instr[15]}}, instr[15:0]};
            addr   = a + simm;
            nextPc = pc + 32'd4;
            dest   = instr[20:16];
            res    = '0;
            wr     = 1'b0;
            case (instr[31:26])
                isaPkg::OP_SPECIAL: begin
                    dest = instr[15:11];
                    wr   = 1'b1;
                    case (instr[5:0])
                        isaPkg::FN_SLL:  res = b << instr[10:6];
                        isaPkg::FN_SRL:  res = b >> instr[10:6];
                        isaPkg::FN_ADDU: res = a + b;
                        isaPkg::FN_SUBU: res = a - b;
                        isaPkg::FN_AND:  res = a & b;
                        isaPkg::FN_OR:   res = a | b;
                        isaPkg::FN_XOR:  res = a ^ b;
                        isaPkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:         wr = 1'b0;
                    endcase
                end
                isaPkg::OP_ADDIU: begin
                    res = addr;
                    wr  = 1'b1;
                end
                isaPkg::OP_ANDI: begin
                    res = a & {16'h0, instr[15:0]};
                    wr  = 1'b1;
                end
                isaPkg::OP_ORI: begin
                    res = a | {16'h0, instr[15:0]};
                    wr  = 1'b1;
                end
                isaPkg::OP_LUI: begin
                    res = {instr[15:0], 16'h0};
                    wr  = 1'b1;
                end
                isaPkg::OP_LW: begin
                    res = mem[addr[7:2]];
                    wr  = 1'b1;
                end
                isaPkg::OP_SW: begin
                    mem[addr[7:2]] = b;
                    expSt.push_back({addr, b});
                end
                isaPkg::OP_BEQ: begin
                    if (a == b) nextPc = pc + 32'd4 + (simm << 2);
                end
                isaPkg::OP_BNE: begin
                    if (a != b) nextPc = pc + 32'd4 + (simm << 2);
                end
                isaPkg::OP_J: nextPc = {nextPc[31:28], instr[25:0], 2'b00};
                isaPkg::OP_JAL: begin
                    res    = pc + 32'd4;
                    dest   = isaPkg::LINK_REG;
                    wr     = 1'b1;
                    nextPc = {nextPc[31:28], instr[25:0], 2'b00};
                end
                default: ; // anything else is a nop
            endcase
            if (wr && dest != '0) begin
                regs[dest] = res;
                expWb.push_back({pc, dest, res});
            end
            done = (nextPc == pc); // end loop reached
            pc   = nextPc;
            steps++;
        end
        assert (done) else begin
            otherErrors++;
            $display("reference model found no end loop within %0d instructions", MODEL_STEPS);
        end
    endtask

    always @(negedge clk) begin
        wbEntryT    wbExp;
        storeEntryT stExp;
        if (rst_i) begin
            checkValue("wbValid_o", '0, {31'b0, wbValid_o});
            checkValue("dmemEn_o", '0, {31'b0, dmemEn_o});
        end else begin
            if (wbValid_o) begin
                assert (expWb.size() != 0) else begin
                    otherErrors++;
                    $display("unexpected writeback at %0t ns from pc %h to r%0d",
                             $time, wbPc_o, wbReg_o);
                end
                if (expWb.size() != 0) begin
                    wbExp = expWb.pop_front();
                    checkValue("wbPc_o", wbExp.pc, wbPc_o);
                    checkValue("wbReg_o", {27'b0, wbExp.dest}, {27'b0, wbReg_o});
                    checkValue("wbData_o", wbExp.data, wbData_o);
                end
            end
            if (dmemEn_o && dmemWe_o) begin
                assert (expSt.size() != 0) else begin
                    otherErrors++;
                    $display("unexpected store at %0t ns to address %h", $time, dmemAddr_o);
                end
                if (expSt.size() != 0) begin
                    stExp = expSt.pop_front();
                    checkValue("dmemAddr_o", stExp.addr, dmemAddr_o);
                    checkValue("dmemWdata_o", stExp.data, dmemWdata_o);
                end
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(RAND_SEED));
        clk   = 1'b0;
        rst_i = 1'b1;
        for (int i = 0; i < 256; i++) begin
            rom[i] = {6'h3f, i[25:0]}; // undefined opcode, runs as nop
        end
        $readmemh("tb/prog.hex", rom);
        for (int i = 0; i < 64; i++) begin
            initWords[i] = $urandom();
        end
        runModel();

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_i = 1'b0;
        @(negedge clk);
        checkValue("imemAddr_o", RESET_PC, imemAddr_o);
        checkValue("wbValid_o", '0, {31'b0, wbValid_o});
        checkValue("dmemEn_o", '0, {31'b0, dmemEn_o});

        cycles = 0;
        while ((expWb.size() != 0 || expSt.size() != 0) && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        assert (expWb.size() == 0 && expSt.size() == 0) else begin
            otherErrors++;
            $display("timeout: %0d writebacks and %0d stores still pending after %0d cycles",
                     expWb.size(), expSt.size(), cycles);
        end
        repeat (DRAIN_CYCLES) @(posedge clk); // the end loop must stay quiet

        $display("Error count: %0d value mismatches, %0d other failures",
                 valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter pipePkg::wordT RESET_PC = '0
) (
    input  wire             clk,
    input  wire             rst_i,
    output pipePkg::wordT   imemAddr_o,
    input  pipePkg::wordT   imemData_i,
    output logic            dmemEn_o,
    output logic            dmemWe_o,
    output pipePkg::wordT   dmemAddr_o,
    output pipePkg::wordT   dmemWdata_o,
    input  pipePkg::wordT   dmemRdata_i,
    output logic            wbValid_o,
    output pipePkg::wordT   wbPc_o,
    output pipePkg::wordT   wbData_o,
    output isaPkg::regAddrT wbReg_o
);

    pipePkg::ifIdT     ifId;
    pipePkg::idExT     idEx;
    pipePkg::exMemT    exMem;
    pipePkg::memWbT    memWb;
    pipePkg::redirectT redirect;
    pipePkg::fwdSelE   fwdA, fwdB;
    pipePkg::wordT     rsData, rtData, memFwd;
    isaPkg::regAddrT   rsAddr, rtAddr;
    logic              stall, squash;

    fetchStage #(.RESET_PC(RESET_PC)) fetchStage_inst (
        .clk(clk), .rst_i(rst_i),
        .stall_i(stall), .squash_i(squash),
        .redirect_i(redirect), .instr_i(imemData_i),
        .pc_o(imemAddr_o), .ifId_o(ifId)
    );

    regFile regFile_inst (
        .clk(clk),
        .raddrA_i(rsAddr), .raddrB_i(rtAddr),
        .rdataA_o(rsData), .rdataB_o(rtData),
        .wb_i(memWb)
    );

    decodeStage decodeStage_inst (
        .clk(clk), .rst_i(rst_i),
        .stall_i(stall), .squash_i(squash),
        .ifId_i(ifId), .rsData_i(rsData), .rtData_i(rtData),
        .rsAddr_o(rsAddr), .rtAddr_o(rtAddr), .idEx_o(idEx)
    );

    executeStage executeStage_inst (
        .clk(clk), .rst_i(rst_i),
        .idEx_i(idEx), .fwdA_i(fwdA), .fwdB_i(fwdB),
        .memFwd_i(memFwd), .wbFwd_i(memWb),
        .redirect_o(redirect), .exMem_o(exMem)
    );

    memoryStage memoryStage_inst (
        .clk(clk), .rst_i(rst_i),
        .exMem_i(exMem), .dmemRdata_i(dmemRdata_i),
        .dmemEn_o(dmemEn_o), .dmemWe_o(dmemWe_o),
        .dmemAddr_o(dmemAddr_o), .dmemWdata_o(dmemWdata_o),
        .memFwd_o(memFwd), .memWb_o(memWb)
    );

    hazardUnit hazardUnit_inst (
        .idEx_i(idEx), .exMem_i(exMem), .memWb_i(memWb),
        .rsAddr_i(rsAddr), .rtAddr_i(rtAddr), .redirect_i(redirect),
        .stall_o(stall), .squash_o(squash),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

    // trace, regWrite already implies valid and a nonzero dest
    assign wbValid_o = memWb.regWrite;
    assign wbPc_o    = memWb.pc;
    assign wbReg_o   = memWb.dest;
    assign wbData_o  = memWb.data;

endmodule

`default_nettype wire

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  pipePkg::idExT     idEx_i,
    input  pipePkg::exMemT    exMem_i,
    input  pipePkg::memWbT    memWb_i,
    input  isaPkg::regAddrT   rsAddr_i,
    input  isaPkg::regAddrT   rtAddr_i,
    input  pipePkg::redirectT redirect_i,
    output logic              stall_o,
    output logic              squash_o,
    output pipePkg::fwdSelE   fwdA_o,
    output pipePkg::fwdSelE   fwdB_o
);

    logic loadInEx;

    // memory stage is younger, so it wins over writeback
    function automatic pipePkg::fwdSelE pickSource(
        input isaPkg::regAddrT src,
        input pipePkg::exMemT  ex,
        input pipePkg::memWbT  wb
    );
        if (ex.regWrite && !ex.memRead && ex.dest == src) begin
            return pipePkg::FWD_MEM;
        end else if (wb.regWrite && wb.dest == src) begin
            return pipePkg::FWD_WB;
        end
        return pipePkg::FWD_REG;
    endfunction

    assign fwdA_o = pickSource(idEx_i.rs, exMem_i, memWb_i);
    assign fwdB_o = pickSource(idEx_i.rt, exMem_i, memWb_i);

    // regWrite is never set for r0, so no zero check here
    assign loadInEx = idEx_i.memRead && idEx_i.regWrite;
    assign stall_o  = loadInEx && (idEx_i.dest == rsAddr_i || idEx_i.dest == rtAddr_i);

    assign squash_o = redirect_i.taken;

endmodule

`default_nettype wire

// ==== logic/memoryStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  wire            clk,
    input  wire            rst_i,
    input  pipePkg::exMemT exMem_i,
    input  pipePkg::wordT  dmemRdata_i,
    output logic           dmemEn_o,
    output logic           dmemWe_o,
    output pipePkg::wordT  dmemAddr_o,
    output pipePkg::wordT  dmemWdata_o,
    output pipePkg::wordT  memFwd_o,
    output pipePkg::memWbT memWb_o
);

    assign dmemEn_o    = exMem_i.valid && (exMem_i.memRead || exMem_i.memWrite);
    assign dmemWe_o    = exMem_i.valid && exMem_i.memWrite;
    assign dmemAddr_o  = exMem_i.result;
    assign dmemWdata_o = exMem_i.storeData;

    // load data is never forwarded from here, hazard unit stalls instead
    assign memFwd_o = exMem_i.result;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            memWb_o <= '0;
        end else begin
            memWb_o.valid    <= exMem_i.valid;
            memWb_o.pc       <= exMem_i.pc;
            memWb_o.dest     <= exMem_i.dest;
            memWb_o.data     <= exMem_i.memRead ? dmemRdata_i : exMem_i.result;
            memWb_o.regWrite <= exMem_i.valid && exMem_i.regWrite;
        end
    end

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire               clk,
    input  wire               rst_i,
    input  pipePkg::idExT     idEx_i,
    input  pipePkg::fwdSelE   fwdA_i,
    input  pipePkg::fwdSelE   fwdB_i,
    input  pipePkg::wordT     memFwd_i,
    input  pipePkg::memWbT    wbFwd_i,
    output pipePkg::redirectT redirect_o,
    output pipePkg::exMemT    exMem_o
);

    pipePkg::wordT rsVal;
    pipePkg::wordT rtVal;
    pipePkg::wordT opB;
    pipePkg::wordT aluOut;
    logic          branchTaken;

    function automatic pipePkg::wordT pickOperand(
        input pipePkg::fwdSelE sel,
        input pipePkg::wordT   regVal,
        input pipePkg::wordT   memVal,
        input pipePkg::wordT   wbVal
    );
        case (sel)
            pipePkg::FWD_MEM: return memVal;
            pipePkg::FWD_WB:  return wbVal;
            default:          return regVal;
        endcase
    endfunction

    assign rsVal = pickOperand(fwdA_i, idEx_i.rsValue, memFwd_i, wbFwd_i.data);
    assign rtVal = pickOperand(fwdB_i, idEx_i.rtValue, memFwd_i, wbFwd_i.data);
    assign opB   = idEx_i.useImm ? idEx_i.imm : rtVal;

    always_comb begin
        case (idEx_i.aluOp)
            isaPkg::ALU_ADD: aluOut = rsVal + opB;
            isaPkg::ALU_SUB: aluOut = rsVal - opB;
            isaPkg::ALU_AND: aluOut = rsVal & opB;
            isaPkg::ALU_OR:  aluOut = rsVal | opB;
            isaPkg::ALU_XOR: aluOut = rsVal ^ opB;
            isaPkg::ALU_SLT: aluOut = {31'b0, $signed(rsVal) < $signed(opB)};
            isaPkg::ALU_SLL: aluOut = opB << idEx_i.shamt;
            isaPkg::ALU_SRL: aluOut = opB >> idEx_i.shamt;
            isaPkg::ALU_LUI: aluOut = {opB[15:0], 16'b0};
            default:         aluOut = opB;
        endcase
    end

    always_comb begin
        case (idEx_i.branchKind)
            pipePkg::BR_EQ: branchTaken = (rsVal == rtVal);
            pipePkg::BR_NE: branchTaken = (rsVal != rtVal);
            default:        branchTaken = 1'b0;
        endcase
    end

    // no delay slot, younger instructions get squashed
    assign redirect_o.taken  = idEx_i.valid && (idEx_i.jump || branchTaken);
    assign redirect_o.target = idEx_i.jumpTarget;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exMem_o <= '0;
        end else begin
            exMem_o.valid     <= idEx_i.valid;
            exMem_o.pc        <= idEx_i.pc;
            exMem_o.result    <= idEx_i.link ? idEx_i.pc + 32'd4 : aluOut; // jal links pc+4
            exMem_o.storeData <= rtVal;
            exMem_o.dest      <= idEx_i.dest;
            exMem_o.regWrite  <= idEx_i.regWrite;
            exMem_o.memRead   <= idEx_i.memRead;
            exMem_o.memWrite  <= idEx_i.memWrite;
        end
    end

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire             clk,
    input  wire             rst_i,
    input  wire             stall_i,
    input  wire             squash_i,
    input  pipePkg::ifIdT   ifId_i,
    input  pipePkg::wordT   rsData_i,
    input  pipePkg::wordT   rtData_i,
    output isaPkg::regAddrT rsAddr_o,
    output isaPkg::regAddrT rtAddr_o,
    output pipePkg::idExT   idEx_o
);

    isaPkg::opcodeE              opcode;
    isaPkg::functE               funct;
    isaPkg::regAddrT             rdAddr;
    logic [isaPkg::IMM_W-1:0]    imm16;
    pipePkg::wordT               pcPlus4;
    pipePkg::wordT               immSext;
    pipePkg::idExT               dec;
    logic                        writesReg;

    assign opcode   = isaPkg::opcodeE'(ifId_i.instr[31:26]);
    assign funct    = isaPkg::functE'(ifId_i.instr[5:0]);
    assign rsAddr_o = ifId_i.instr[25:21];
    assign rtAddr_o = ifId_i.instr[20:16];
    assign rdAddr   = ifId_i.instr[15:11];
    assign imm16    = ifId_i.instr[15:0];
    assign pcPlus4  = ifId_i.pc + 32'd4;
    assign immSext  = {{(32 - isaPkg::IMM_W){imm16[isaPkg::IMM_W-1]}}, imm16};

    always_comb begin
        dec            = '0;
        dec.valid      = ifId_i.valid;
        dec.pc         = ifId_i.pc;
        dec.rs         = rsAddr_o;
        dec.rt         = rtAddr_o;
        dec.dest       = rtAddr_o; // I-type default
        dec.rsValue    = rsData_i;
        dec.rtValue    = rtData_i;
        dec.imm        = immSext;
        dec.shamt      = ifId_i.instr[10:6];
        dec.aluOp      = isaPkg::ALU_PASSB;
        dec.branchKind = pipePkg::BR_NONE;
        dec.jumpTarget = pcPlus4 + {immSext[29:0], 2'b00};
        writesReg      = 1'b0;
        case (opcode)
            isaPkg::OP_SPECIAL: begin
                dec.dest  = rdAddr;
                writesReg = 1'b1;
                case (funct)
                    isaPkg::FN_SLL:  dec.aluOp = isaPkg::ALU_SLL;
                    isaPkg::FN_SRL:  dec.aluOp = isaPkg::ALU_SRL;
                    isaPkg::FN_ADDU: dec.aluOp = isaPkg::ALU_ADD;
                    isaPkg::FN_SUBU: dec.aluOp = isaPkg::ALU_SUB;
                    isaPkg::FN_AND:  dec.aluOp = isaPkg::ALU_AND;
                    isaPkg::FN_OR:   dec.aluOp = isaPkg::ALU_OR;
                    isaPkg::FN_XOR:  dec.aluOp = isaPkg::ALU_XOR;
                    isaPkg::FN_SLT:  dec.aluOp = isaPkg::ALU_SLT;
                    default:         writesReg = 1'b0; // unknown funct, nop
                endcase
            end
            isaPkg::OP_ADDIU, isaPkg::OP_LW: begin
                dec.aluOp   = isaPkg::ALU_ADD;
                dec.useImm  = 1'b1;
                dec.memRead = (opcode == isaPkg::OP_LW);
                writesReg   = 1'b1;
            end
            isaPkg::OP_SW: begin
                dec.aluOp    = isaPkg::ALU_ADD;
                dec.useImm   = 1'b1;
                dec.memWrite = 1'b1;
            end
            isaPkg::OP_ANDI, isaPkg::OP_ORI: begin
                dec.aluOp  = (opcode == isaPkg::OP_ANDI) ? isaPkg::ALU_AND : isaPkg::ALU_OR;
                dec.imm    = {{(32 - isaPkg::IMM_W){1'b0}}, imm16}; // zero extended
                dec.useImm = 1'b1;
                writesReg  = 1'b1;
            end
            isaPkg::OP_LUI: begin
                dec.aluOp  = isaPkg::ALU_LUI;
                dec.useImm = 1'b1;
                writesReg  = 1'b1;
            end
            isaPkg::OP_BEQ: dec.branchKind = pipePkg::BR_EQ;
            isaPkg::OP_BNE: dec.branchKind = pipePkg::BR_NE;
            isaPkg::OP_J, isaPkg::OP_JAL: begin
                dec.jump       = 1'b1;
                dec.jumpTarget = {pcPlus4[31:28], ifId_i.instr[25:0], 2'b00};
                if (opcode == isaPkg::OP_JAL) begin
                    dec.link  = 1'b1;
                    dec.dest  = isaPkg::LINK_REG;
                    writesReg = 1'b1;
                end
            end
            default: ; // undefined opcode runs as nop
        endcase
        dec.regWrite = writesReg && (dec.dest != '0);
        if (!ifId_i.valid) begin
            dec = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || stall_i || squash_i) begin
            idEx_o <= '0; // bubble
        end else begin
            idEx_o <= dec;
        end
    end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire             clk,
    input  isaPkg::regAddrT raddrA_i,
    input  isaPkg::regAddrT raddrB_i,
    output pipePkg::wordT   rdataA_o,
    output pipePkg::wordT   rdataB_o,
    input  pipePkg::memWbT  wb_i
);

    pipePkg::wordT regs [32];

    logic writeEn;

    assign writeEn = wb_i.regWrite && (wb_i.dest != '0);

    always_ff @(posedge clk) begin
        if (writeEn) begin
            regs[wb_i.dest] <= wb_i.data;
        end
    end

    // writeback in the same cycle bypasses the array
    always_comb begin
        if (raddrA_i == '0) begin
            rdataA_o = '0;
        end else if (writeEn && wb_i.dest == raddrA_i) begin
            rdataA_o = wb_i.data;
        end else begin
            rdataA_o = regs[raddrA_i];
        end
    end

    always_comb begin
        if (raddrB_i == '0) begin
            rdataB_o = '0;
        end else if (writeEn && wb_i.dest == raddrB_i) begin
            rdataB_o = wb_i.data;
        end else begin
            rdataB_o = regs[raddrB_i];
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter pipePkg::wordT RESET_PC = '0
) (
    input  wire               clk,
    input  wire               rst_i,
    input  wire               stall_i,
    input  wire               squash_i,
    input  pipePkg::redirectT redirect_i,
    input  pipePkg::wordT     instr_i,
    output pipePkg::wordT     pc_o,
    output pipePkg::ifIdT     ifId_o
);

    pipePkg::wordT pc;
    pipePkg::wordT pcNext;

    always_comb begin
        if (redirect_i.taken) begin
            pcNext = redirect_i.target;
        end else if (stall_i) begin
            pcNext = pc; // load-use hold
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    // wrong-path fetch is dropped on squash
    always_ff @(posedge clk) begin
        if (rst_i || squash_i) begin
            ifId_o <= '0;
        end else if (!stall_i) begin
            ifId_o.valid <= 1'b1;
            ifId_o.pc    <= pc;
            ifId_o.instr <= instr_i;
        end
    end

    assign pc_o = pc;

endmodule

`default_nettype wire

// ==== logic/pipePkg.sv ====
`default_nettype none

package pipePkg;

    typedef logic [31:0] wordT;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branchKindE;

    typedef enum logic [1:0] {
        FWD_REG, // value read in decode
        FWD_MEM,
        FWD_WB
    } fwdSelE;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        logic                           valid;
        wordT                           pc;
        isaPkg::aluOpE                  aluOp;
        isaPkg::regAddrT                rs;
        isaPkg::regAddrT                rt;
        isaPkg::regAddrT                dest;
        wordT                           rsValue;
        wordT                           rtValue;
        wordT                           imm;
        logic [isaPkg::SHAMT_W-1:0]     shamt;
        logic                           useImm;
        logic                           regWrite;
        logic                           memRead;
        logic                           memWrite;
        branchKindE                     branchKind;
        logic                           jump;
        logic                           link;
        wordT                           jumpTarget; // branch or jump destination
    } idExT;

    typedef struct packed {
        logic            valid;
        wordT            pc;
        wordT            result;
        wordT            storeData;
        isaPkg::regAddrT dest;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
    } exMemT;

    typedef struct packed {
        logic            valid;
        wordT            pc;
        isaPkg::regAddrT dest;
        wordT            data;
        logic            regWrite;
    } memWbT;

    typedef struct packed {
        logic taken;
        wordT target;
    } redirectT;

endpackage

`default_nettype wire

// ==== logic/isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;
    localparam int ALU_OP_W   = 4;
    localparam int REG_ADDR_W = 5;

    typedef logic [REG_ADDR_W-1:0] regAddrT;

    localparam regAddrT LINK_REG = 5'd31; // written by jal

    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'h00, // R-type, operation in funct
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeE;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } functE;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI,
        ALU_PASSB // nops, branches and jumps
    } aluOpE;

endpackage

`default_nettype wire
